/* common/cpu_consts.svh */
/*
 * CPU constants
 * Word width, reset vector, RV32I opcodes and funct3 codes
 * shared by the core blocks and the testbench
 */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_XLEN        32
`define CPU_RESET_PC    32'h0000_8000   // First fetch address

// ------------------------------
// Major opcodes, instr[6:0]
`define CPU_OP_LOAD     7'h03
`define CPU_OP_STORE    7'h23
`define CPU_OP_BRANCH   7'h63
`define CPU_OP_JAL      7'h6f
`define CPU_OP_JALR     7'h67
`define CPU_OP_IMM      7'h13
`define CPU_OP_REG      7'h33
`define CPU_OP_LUI      7'h37
`define CPU_OP_AUIPC    7'h17
`define CPU_OP_SYSTEM   7'h73

// ------------------------------
// Branch conditions
`define CPU_F3_BEQ      3'h0
`define CPU_F3_BNE      3'h1
`define CPU_F3_BLT      3'h4
`define CPU_F3_BGE      3'h5
`define CPU_F3_BLTU     3'h6
`define CPU_F3_BGEU     3'h7

// Load widths, bit 2 set means zero extension
`define CPU_F3_LB       3'h0
`define CPU_F3_LH       3'h1
`define CPU_F3_LW       3'h2
`define CPU_F3_LBU      3'h4
`define CPU_F3_LHU      3'h5

`define CPU_EBREAK_IMM  12'h001         // imm field of EBREAK, funct3 is 0

`endif

/* common/cpu_pkg.sv */
/*
 * CPU types
 * FSM states, ALU operations, the decoded instruction record
 * and the memory request bundle driven by the core
 */
package cpu_pkg;

`include "cpu_consts.svh"

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [4:0]           reg_idx_t;

    // One instruction walks through these in order, MEMORY only for loads and stores
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4
    } cpu_state_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10   // LUI, immediate straight through
    } alu_op_e;

    typedef struct packed {
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] funct3;
        word_t      imm;
        alu_op_e    alu_op;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       is_auipc;
        logic       is_ebreak;
        logic       use_imm;     // Immediate as ALU operand b
        logic       writes_rd;
    } decoded_t;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;       // Unshifted rs2, memory places the lane
        logic       read;
        logic       write;
        logic [1:0] width;       // 0 byte, 1 half, 2 word
    } mem_req_t;

endpackage

/* core/cpu_decoder.sv */
/*
 * Instruction decoder
 * Splits an RV32I word into register fields, builds the immediate
 * for its format and classifies it for the control FSM and the ALU
 */
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpu_decoder import cpu_pkg::*; (
    input  word_t    instr,
    output decoded_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // ------------------------------
    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec        = '0;
        dec.rd     = instr[11:7];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.funct3 = funct3;
        dec.alu_op = ADD;               // Address and AUIPC sums

        case (opcode)
            `CPU_OP_LOAD: begin
                dec.imm       = imm_i;
                dec.is_load   = 1'b1;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            `CPU_OP_STORE: begin
                dec.imm      = imm_s;
                dec.is_store = 1'b1;
                dec.use_imm  = 1'b1;
            end
            `CPU_OP_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                dec.alu_op    = SUB;    // Compare itself is done in control
            end
            `CPU_OP_JAL: begin
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.writes_rd = 1'b1;
            end
            `CPU_OP_JALR: begin
                dec.imm       = imm_i;
                dec.is_jalr   = 1'b1;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            `CPU_OP_LUI: begin
                dec.imm       = imm_u;
                dec.alu_op    = PASS_B;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            `CPU_OP_AUIPC: begin
                dec.imm       = imm_u;
                dec.is_auipc  = 1'b1;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            `CPU_OP_IMM, `CPU_OP_REG: begin
                dec.imm       = imm_i;
                dec.use_imm   = (opcode == `CPU_OP_IMM);
                dec.writes_rd = 1'b1;
                case (funct3)
                    3'd0: dec.alu_op = (opcode == `CPU_OP_REG && instr[30]) ? SUB : ADD;
                    3'd1: dec.alu_op = SLL;
                    3'd2: dec.alu_op = SLT;
                    3'd3: dec.alu_op = SLTU;
                    3'd4: dec.alu_op = XOR;
                    3'd5: dec.alu_op = instr[30] ? SRA : SRL;
                    3'd6: dec.alu_op = OR;
                    default: dec.alu_op = AND;
                endcase
            end
            `CPU_OP_SYSTEM: begin
                // Anything but EBREAK runs as a no-op
                dec.is_ebreak = (funct3 == 3'd0) && (instr[31:20] == `CPU_EBREAK_IMM);
            end
            default: ;
        endcase
    end

endmodule

/* core/cpu_alu.sv */
/*
 * ALU
 * Combinational add, subtract, logic, shift and set-less-than,
 * plus a pass of operand b for LUI
 */
`timescale 1ns/100ps

module cpu_alu import cpu_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];      // RV32 shifts use only the low 5 bits

    always_comb begin
        case (op)
            ADD:    result = a + b;
            SUB:    result = a - b;
            SLL:    result = a << shamt;
            SLT:    result = {31'b0, $signed(a) < $signed(b)};
            SLTU:   result = {31'b0, a < b};
            XOR:    result = a ^ b;
            SRL:    result = a >> shamt;
            SRA:    result = $signed(a) >>> shamt;   // Sign bit fills from the left
            OR:     result = a | b;
            AND:    result = a & b;
            PASS_B: result = b;
            default: result = '0;
        endcase
    end

endmodule

/* core/cpu_regfile.sv */
/*
 * Register file
 * x1..x31 with two combinational read ports and one write port,
 * x0 is hardwired to zero
 */
`timescale 1ns/100ps

module cpu_regfile import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  reg_idx_t rd,
    input  word_t    rd_data,
    input  logic     rd_we
);

    word_t regs [1:31];     // No storage behind x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // Reads come a state after any write, so no bypass
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* core/cpu_load_align.sv */
/*
 * Load aligner
 * Picks the byte or half lane of a loaded word by the low address
 * bits and sign or zero extends it to a full word
 */
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpu_load_align import cpu_pkg::*; (
    input  word_t      word,
    input  logic [1:0] offset,
    input  logic [2:0] funct3,
    output word_t      data
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    always_comb begin
        case (offset)
            2'd0:    byte_lane = word[7:0];
            2'd1:    byte_lane = word[15:8];
            2'd2:    byte_lane = word[23:16];
            default: byte_lane = word[31:24];
        endcase
    end

    assign half_lane = offset[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (funct3)
            `CPU_F3_LB:  data = {{24{byte_lane[7]}}, byte_lane};
            `CPU_F3_LH:  data = {{16{half_lane[15]}}, half_lane};
            `CPU_F3_LBU: data = {24'b0, byte_lane};
            `CPU_F3_LHU: data = {16'b0, half_lane};
            default:     data = word;   // LW
        endcase
    end

endmodule

/* core/cpu_control.sv */
/*
 * Core control
 * Multicycle FSM FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK that holds
 * the PC and instruction, picks ALU operands, resolves jumps and branches,
 * drives the memory request and the register write, and halts on EBREAK
 */
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpu_control import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     mem_ready,
    input  word_t    mem_rdata,
    output mem_req_t mem_req,
    output logic     halted,
    output word_t    instr,
    input  decoded_t dec,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output reg_idx_t rd,
    output logic     rd_we,
    output word_t    rd_data
);

    cpu_state_e state, next_state;
    word_t      pc_q;           // PC of the instruction in flight
    word_t      instr_q;
    word_t      alu_q;          // Result, address or link value
    word_t      mem_q;          // Raw loaded word
    logic       halted_q;
    logic       advance;
    logic       branch_taken;
    word_t      alu_a, alu_b, alu_y;
    word_t      pc_plus4, pc_target, next_pc;
    word_t      load_data;

    assign advance = mem_ready && !halted_q;    // Back-pressure freezes everything

    // ------------------------------
    // Datapath
    assign alu_a = dec.is_auipc ? pc_q : rs1_data;
    assign alu_b = dec.use_imm ? dec.imm : rs2_data;

    cpu_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_y)
    );

    cpu_load_align u_load_align (
        .word   (mem_q),
        .offset (alu_q[1:0]),
        .funct3 (dec.funct3),
        .data   (load_data)
    );

    always_comb begin
        case (dec.funct3)
            `CPU_F3_BEQ:  branch_taken = (rs1_data == rs2_data);
            `CPU_F3_BNE:  branch_taken = (rs1_data != rs2_data);
            `CPU_F3_BLT:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            `CPU_F3_BGE:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            `CPU_F3_BLTU: branch_taken = (rs1_data < rs2_data);
            `CPU_F3_BGEU: branch_taken = (rs1_data >= rs2_data);
            default:      branch_taken = 1'b0;
        endcase
    end

    assign pc_plus4  = pc_q + 32'd4;
    assign pc_target = pc_q + dec.imm;

    always_comb begin
        if (dec.is_jal)
            next_pc = pc_target;
        else if (dec.is_jalr)
            next_pc = {alu_y[31:1], 1'b0};
        else if (dec.is_branch && branch_taken)
            next_pc = pc_target;
        else
            next_pc = pc_plus4;
    end

    // ------------------------------
    // FSM
    always_comb begin
        case (state)
            FETCH:     next_state = DECODE;
            DECODE:    next_state = EXECUTE;
            EXECUTE: begin
                if (dec.is_ebreak)
                    next_state = EXECUTE;           // Parks here once halted
                else if (dec.is_load || dec.is_store)
                    next_state = MEMORY;
                else
                    next_state = WRITEBACK;
            end
            MEMORY:    next_state = WRITEBACK;
            default:   next_state = FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= FETCH;
            pc_q     <= `CPU_RESET_PC;
            instr_q  <= '0;
            halted_q <= 1'b0;
        end else if (advance) begin
            state <= next_state;
            case (state)
                FETCH:   instr_q <= mem_rdata;
                EXECUTE: begin
                    pc_q <= next_pc;
                    if (dec.is_ebreak)
                        halted_q <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (advance && state == EXECUTE)
            alu_q <= (dec.is_jal || dec.is_jalr) ? pc_plus4 : alu_y;   // Link value for jumps
        if (advance && state == MEMORY)
            mem_q <= mem_rdata;
    end

    // ------------------------------
    // Memory request, held state only
    always_comb begin
        mem_req       = '0;
        mem_req.addr  = (state == MEMORY) ? alu_q : pc_q;
        mem_req.wdata = rs2_data;
        mem_req.width = (state == MEMORY) ? dec.funct3[1:0] : 2'd2;
        mem_req.read  = !halted_q && ((state == FETCH) || (state == MEMORY && dec.is_load));
        mem_req.write = !halted_q && (state == MEMORY) && dec.is_store;
    end

    assign instr   = instr_q;
    assign halted  = halted_q;
    assign rd      = dec.rd;
    assign rd_data = dec.is_load ? load_data : alu_q;
    assign rd_we   = advance && (state == WRITEBACK) && dec.writes_rd;

endmodule

/* hdl/cpu_top.sv */
/*
 * CPU top
 * Multicycle RV32I core, control and decode around the register file,
 * one memory port for fetch, load and store
 */
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    output mem_req_t mem_req,
    input  word_t    mem_rdata,
    input  logic     mem_ready,
    output logic     halted
);

    word_t    instr;
    decoded_t dec;
    word_t    rs1_data, rs2_data;
    reg_idx_t rd;
    word_t    rd_data;
    logic     rd_we;

    cpu_control u_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .halted    (halted),
        .instr     (instr),
        .dec       (dec),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .rd        (rd),
        .rd_we     (rd_we),
        .rd_data   (rd_data)
    );

    cpu_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    // Read ports follow the held instruction
    cpu_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd       (rd),
        .rd_data  (rd_data),
        .rd_we    (rd_we)
    );

endmodule

/* testbench/tb_checker.sv */
/*
 * Store checker
 * Watches the memory port, checks the first fetch after reset,
 * compares every store in order with the expected table and
 * flags any bus request from a halted core
 */
`timescale 1ns/100ps

module tb_checker import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t mem_req,
    input  logic     mem_ready,
    input  logic     halted,
    input  logic     run_end,
    output int       errors,
    output int       compared
);

    localparam word_t FIRST_FETCH = 32'h0000_8000;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic [1:0] width;
    } store_t;

    store_t expected [$];
    int     next_idx;
    bit     first_req;      // First request after reset still to be checked

    task automatic add_store(input word_t addr, input word_t wdata, input logic [1:0] width);
        expected.push_back({addr, wdata, width});
    endtask

    task automatic compare_field(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("Error at t=%0t: %s", $time, what);
        errors++;
    endtask

    task automatic check_store();
        store_t want;
        if (next_idx >= expected.size()) begin
            report_error($sformatf("store to %h beyond the end of the table", mem_req.addr));
        end else begin
            want = expected[next_idx];
            compare_field("mem_req.addr", mem_req.addr, want.addr);
            compare_field("mem_req.wdata", mem_req.wdata, want.wdata);
            compare_field("mem_req.width", {30'b0, mem_req.width}, {30'b0, want.width});
            compared++;
        end
        next_idx++;
    endtask

    // ------------------------------
    // Expected stores worked out by hand from the program
    initial begin
        errors   = 0;
        compared = 0;
        add_store(32'h0000_9100, 32'h0000_005d, 2'd2);   // 100 + -7
        add_store(32'h0000_9104, 32'hffff_ff95, 2'd2);   // -7 - 100
        add_store(32'h0000_9108, 32'hffff_ff9d, 2'd2);
        add_store(32'h0000_910c, 32'hffff_fffd, 2'd2);
        add_store(32'h0000_9110, 32'h0000_00f0, 2'd2);
        add_store(32'h0000_9114, 32'h0000_0640, 2'd2);
        add_store(32'h0000_9118, 32'hffff_fffc, 2'd2);   // Arithmetic shift rounds down
        add_store(32'h0000_911c, 32'h0000_000f, 2'd2);
        add_store(32'h0000_9120, 32'h0000_0001, 2'd2);
        add_store(32'h0000_9124, 32'h0000_0000, 2'd2);
        add_store(32'h0000_9128, 32'habcd_e000, 2'd2);
        add_store(32'h0000_912c, 32'h0000_9060, 2'd2);   // AUIPC at 0x8060
        add_store(32'h0000_9130, 32'h0000_007e, 2'd2);
        add_store(32'h0000_9134, 32'hffff_fff0, 2'd2);
        add_store(32'h0000_9138, 32'h0000_0081, 2'd2);
        add_store(32'h0000_913c, 32'hffff_f08c, 2'd2);
        add_store(32'h0000_9140, 32'h0000_7e81, 2'd2);
        add_store(32'h0000_9144, 32'h1234_5678, 2'd2);
        add_store(32'h0000_9148, 32'h0000_0064, 2'd2);
        add_store(32'h0000_914c, 32'h0000_80f0, 2'd2);   // JAL link
        add_store(32'h0000_9150, 32'h0000_8100, 2'd2);   // JALR link
        add_store(32'h0000_9155, 32'hffff_fff9, 2'd0);
        add_store(32'h0000_9156, 32'h0000_0064, 2'd1);
    end

    // Sampled mid-cycle where the bus is settled
    always @(negedge clk) begin
        if (!rst_n) begin
            next_idx  = 0;
            first_req = 1'b1;
        end else begin
            if (first_req) begin
                compare_field("mem_req.addr", mem_req.addr, FIRST_FETCH);
                compare_field("mem_req.read", {31'b0, mem_req.read}, 32'd1);
                compare_field("mem_req.write", {31'b0, mem_req.write}, 32'd0);
                compare_field("halted", {31'b0, halted}, 32'd0);
                first_req = 1'b0;
            end
            if (halted && (mem_req.read || mem_req.write))
                report_error("bus request while the core is halted");
            if (mem_ready && mem_req.write)
                check_store();
            if (run_end && next_idx != expected.size())
                report_error($sformatf("%0d stores seen, %0d expected",
                                       next_idx, expected.size()));
        end
    end

endmodule

/* testbench/tb_cpu.sv */
/*
 * CPU testbench
 * Runs a fixed RV32I program from a behavioral memory twice,
 * first with mem_ready held high, then with random back-pressure
 */
`timescale 1ns/100ps
`include "cpu_consts.svh"

module tb_cpu import cpu_pkg::*; ();

    localparam int          MEM_WORDS  = 16384;        // 64 KiB
    localparam word_t       DATA_BASE  = 32'h0000_9000;
    localparam logic [31:0] LFSR_SEED  = 32'hd6ff_5a08;
    localparam int          HALT_LIMIT = 8000;         // Cycles allowed per run

    logic        clk;
    logic        rst_n;
    logic        mem_ready;
    word_t       mem_rdata;
    mem_req_t    mem_req;
    logic        halted;
    logic        run_end;
    logic        rand_ready;
    logic [31:0] lfsr;
    int          errors;
    int          stores;
    int          timeouts;
    bit          ok;

    word_t       mem [0:MEM_WORDS-1];
    word_t       prog [$];                              // Instruction words from the reset PC

    cpu_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .halted    (halted)
    );

    tb_checker chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .halted    (halted),
        .run_end   (run_end),
        .errors    (errors),
        .compared  (stores)
    );

    // ------------------------------
    // Instruction encoders
    function automatic int enc_r(input int f7, input int rs2, input int rs1, input int f3,
                                 input int rd);
        return (f7 << 25) | (rs2 << 20) | (rs1 << 15) | (f3 << 12) | (rd << 7) | `CPU_OP_REG;
    endfunction

    function automatic int enc_i(input int imm, input int rs1, input int f3, input int rd,
                                 input int op);
        return ((imm & 'hfff) << 20) | (rs1 << 15) | (f3 << 12) | (rd << 7) | op;
    endfunction

    function automatic int enc_s(input int imm, input int rs2, input int rs1, input int f3);
        return (((imm >> 5) & 'h7f) << 25) | (rs2 << 20) | (rs1 << 15) | (f3 << 12) |
               ((imm & 'h1f) << 7) | `CPU_OP_STORE;
    endfunction

    function automatic int enc_b(input int imm, input int rs2, input int rs1, input int f3);
        return (((imm >> 12) & 1) << 31) | (((imm >> 5) & 'h3f) << 25) | (rs2 << 20) |
               (rs1 << 15) | (f3 << 12) | (((imm >> 1) & 'hf) << 8) |
               (((imm >> 11) & 1) << 7) | `CPU_OP_BRANCH;
    endfunction

    function automatic int enc_u(input int imm20, input int rd, input int op);
        return (imm20 << 12) | (rd << 7) | op;
    endfunction

    function automatic int enc_j(input int imm, input int rd);
        return (((imm >> 20) & 1) << 31) | (((imm >> 1) & 'h3ff) << 21) |
               (((imm >> 11) & 1) << 20) | (((imm >> 12) & 'hff) << 12) | (rd << 7) |
               `CPU_OP_JAL;
    endfunction

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // Memory places the byte or half itself
    function automatic word_t merge_store(input word_t old, input mem_req_t req);
        word_t w;
        w = old;
        case (req.width)
            2'd0:    w[8*req.addr[1:0] +: 8] = req.wdata[7:0];
            2'd1:    w[16*req.addr[1] +: 16] = req.wdata[15:0];
            default: w = req.wdata;
        endcase
        return w;
    endfunction

    // ------------------------------
    // x10 points at the data area and results go to 0x9100 and up
    task automatic build_program();
        prog.push_back(enc_u('h9, 10, `CPU_OP_LUI));                  // x10 = 0x9000
        prog.push_back(enc_i(100, 0, 0, 1, `CPU_OP_IMM));             // x1 = 100
        prog.push_back(enc_i(-7, 0, 0, 2, `CPU_OP_IMM));              // x2 = -7
        prog.push_back(enc_r(0, 2, 1, 0, 3));                         // add x3
        prog.push_back(enc_s('h100, 3, 10, 2));
        prog.push_back(enc_r('h20, 1, 2, 0, 4));                      // sub x4 = x2 - x1
        prog.push_back(enc_s('h104, 4, 10, 2));
        prog.push_back(enc_r(0, 2, 1, 4, 5));                         // xor
        prog.push_back(enc_s('h108, 5, 10, 2));
        prog.push_back(enc_r(0, 2, 1, 6, 6));                         // or
        prog.push_back(enc_i('hf0, 2, 7, 7, `CPU_OP_IMM));            // andi
        prog.push_back(enc_s('h10c, 6, 10, 2));
        prog.push_back(enc_s('h110, 7, 10, 2));
        prog.push_back(enc_i(4, 1, 1, 8, `CPU_OP_IMM));               // slli
        prog.push_back(enc_i('h401, 2, 5, 9, `CPU_OP_IMM));           // srai by 1
        prog.push_back(enc_i(28, 2, 5, 11, `CPU_OP_IMM));             // srli by 28
        prog.push_back(enc_s('h114, 8, 10, 2));
        prog.push_back(enc_s('h118, 9, 10, 2));
        prog.push_back(enc_s('h11c, 11, 10, 2));
        prog.push_back(enc_r(0, 1, 2, 2, 12));                        // slt x12 = x2 < x1
        prog.push_back(enc_r(0, 1, 2, 3, 13));                        // sltu
        prog.push_back(enc_s('h120, 12, 10, 2));
        prog.push_back(enc_s('h124, 13, 10, 2));
        prog.push_back(enc_u('habcde, 14, `CPU_OP_LUI));
        prog.push_back(enc_u(1, 15, `CPU_OP_AUIPC));                  // At 0x8060
        prog.push_back(enc_s('h128, 14, 10, 2));
        prog.push_back(enc_s('h12c, 15, 10, 2));
        prog.push_back(enc_i(1, 10, `CPU_F3_LB, 16, `CPU_OP_LOAD));
        prog.push_back(enc_s('h130, 16, 10, 2));
        prog.push_back(enc_i(3, 10, `CPU_F3_LB, 17, `CPU_OP_LOAD));
        prog.push_back(enc_s('h134, 17, 10, 2));
        prog.push_back(enc_i(0, 10, `CPU_F3_LBU, 18, `CPU_OP_LOAD));
        prog.push_back(enc_s('h138, 18, 10, 2));
        prog.push_back(enc_i(2, 10, `CPU_F3_LH, 19, `CPU_OP_LOAD));
        prog.push_back(enc_s('h13c, 19, 10, 2));
        prog.push_back(enc_i(0, 10, `CPU_F3_LHU, 20, `CPU_OP_LOAD));
        prog.push_back(enc_s('h140, 20, 10, 2));
        prog.push_back(enc_i(4, 10, `CPU_F3_LW, 21, `CPU_OP_LOAD));
        prog.push_back(enc_s('h144, 21, 10, 2));
        prog.push_back(enc_i('h7ad, 0, 0, 31, `CPU_OP_IMM));          // Poison value
        // Per condition a not-taken branch, a taken branch, then a poison store
        prog.push_back(enc_b(8, 2, 1, `CPU_F3_BEQ));
        prog.push_back(enc_b(8, 1, 1, `CPU_F3_BEQ));
        prog.push_back(enc_s('h1f0, 31, 10, 2));
        prog.push_back(enc_b(8, 1, 1, `CPU_F3_BNE));
        prog.push_back(enc_b(8, 2, 1, `CPU_F3_BNE));
        prog.push_back(enc_s('h1f0, 31, 10, 2));
        prog.push_back(enc_b(8, 2, 1, `CPU_F3_BLT));                  // 100 < -7
        prog.push_back(enc_b(8, 1, 2, `CPU_F3_BLT));
        prog.push_back(enc_s('h1f0, 31, 10, 2));
        prog.push_back(enc_b(8, 1, 2, `CPU_F3_BGE));
        prog.push_back(enc_b(8, 2, 1, `CPU_F3_BGE));
        prog.push_back(enc_s('h1f0, 31, 10, 2));
        prog.push_back(enc_b(8, 1, 2, `CPU_F3_BLTU));                 // Unsigned -7 is large
        prog.push_back(enc_b(8, 2, 1, `CPU_F3_BLTU));
        prog.push_back(enc_s('h1f0, 31, 10, 2));
        prog.push_back(enc_b(8, 2, 1, `CPU_F3_BGEU));
        prog.push_back(enc_b(8, 1, 2, `CPU_F3_BGEU));
        prog.push_back(enc_s('h1f0, 31, 10, 2));
        prog.push_back(enc_s('h148, 1, 10, 2));                       // Through the branches
        prog.push_back(enc_j(8, 22));                                 // jal at 0x80ec
        prog.push_back(enc_s('h1f0, 31, 10, 2));
        prog.push_back(enc_s('h14c, 22, 10, 2));
        prog.push_back(enc_u(0, 24, `CPU_OP_AUIPC));                  // x24 = 0x80f8
        prog.push_back(enc_i(13, 24, 0, 25, `CPU_OP_JALR));           // To 0x8104 with bit 0 dropped
        prog.push_back(enc_s('h1f0, 31, 10, 2));
        prog.push_back(enc_s('h150, 25, 10, 2));
        prog.push_back(enc_s('h155, 2, 10, 0));                       // sb
        prog.push_back(enc_s('h156, 1, 10, 1));                       // sh
        prog.push_back(enc_i(`CPU_EBREAK_IMM, 0, 0, 0, `CPU_OP_SYSTEM));
    endtask

    // ------------------------------
    // Memory model
    assign mem_rdata = mem[mem_req.addr[15:2]];

    // Request and ready are stable here and commit at the next rising edge
    always @(negedge clk) begin
        if (rst_n && mem_ready && mem_req.write)
            mem[mem_req.addr[15:2]] = merge_store(mem[mem_req.addr[15:2]], mem_req);
    end

    always @(posedge clk) begin
        #1;
        if (rand_ready) begin
            lfsr = lfsr_step(lfsr);
            mem_ready = lfsr[0];
        end else begin
            mem_ready = 1'b1;
        end
    end

    task automatic load_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hdead_0000 | (i << 2);      // Own byte address in the low half
        end
        foreach (prog[i]) begin
            mem[(`CPU_RESET_PC >> 2) + i] = prog[i];
        end
        mem[DATA_BASE >> 2]       = 32'hf08c_7e81;     // Bytes 81 7e 8c f0
        mem[(DATA_BASE >> 2) + 1] = 32'h1234_5678;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic wait_halt(input int limit, output bit done);
        int n;
        n = 0;
        while (!halted && n < limit) begin
            @(negedge clk);
            n++;
        end
        done = halted;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n      = 1'b0;
        mem_ready  = 1'b0;
        rand_ready = 1'b0;
        run_end    = 1'b0;
        lfsr       = LFSR_SEED;
        timeouts   = 0;
        build_program();
        for (int run = 0; run < 2; run++) begin
            @(negedge clk);
            rand_ready = (run == 1);
            load_memory();
            apply_reset();
            wait_halt(HALT_LIMIT, ok);
            if (!ok) begin
                $display("Timeout: core did not halt within %0d cycles in run %0d",
                         HALT_LIMIT, run);
                timeouts++;
            end
            repeat (20) @(posedge clk);     // Quiet window after the halt
            #1 run_end = 1'b1;
            @(posedge clk);
            #1 run_end = 1'b0;
        end
        $display("Summary: %0d stores compared, %0d check errors, %0d timeouts",
                 stores, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+common
common/cpu_pkg.sv
core/cpu_decoder.sv
core/cpu_alu.sv
core/cpu_regfile.sv
core/cpu_load_align.sv
core/cpu_control.sv
hdl/cpu_top.sv
testbench/tb_checker.sv
testbench/tb_cpu.sv
